/* src/nn_pkg.sv */
package nn_pkg;

    // Operand widths shared by every stage
    localparam int DATA_W = 8;   // Inputs, weights, hidden activations
    localparam int ACC_W  = 24;  // Accumulator and output scores

    // Sequencer states, also shown on the current_state port
    typedef enum logic [3:0] {
        ST_IDLE   = 4'd0,  // Host may load memories
        ST_LAYER1 = 4'd1,  // Input to hidden MACs
        ST_LAYER2 = 4'd2,  // Hidden to output MACs
        ST_ARGMAX = 4'd3,  // Waiting on the result stage
        ST_DONE   = 4'd4   // One cycle, done high
    } nn_state_t;

endpackage

/* src/nn_buffers.sv */
`timescale 1ns/1ps

module nn_buffers #(
    parameter int  N_IN   = 16,
    parameter int  N_HID  = 8,
    parameter int  N_OUT  = 10,
    localparam int N_W    = N_IN * N_HID + N_HID * N_OUT,
    localparam int IN_AW  = $clog2(N_IN),
    localparam int HID_AW = $clog2(N_HID),
    localparam int ACT_AW = $clog2(N_IN > N_HID ? N_IN : N_HID),
    localparam int W_AW   = $clog2(N_W)
) (
    input  logic                             clk,
    input  logic                             idle,
    input  logic                             in_we,
    input  logic [IN_AW-1:0]                 in_addr,
    input  logic signed [nn_pkg::DATA_W-1:0] in_data,
    input  logic                             w_we,
    input  logic [W_AW-1:0]                  w_addr,
    input  logic signed [nn_pkg::DATA_W-1:0] w_data,
    input  logic                             hid_we,
    input  logic [HID_AW-1:0]                hid_addr,
    input  logic signed [nn_pkg::DATA_W-1:0] hid_data,
    input  logic                             rd_layer,
    input  logic [ACT_AW-1:0]                rd_act_addr,
    input  logic [W_AW-1:0]                  rd_w_addr,
    output logic signed [nn_pkg::DATA_W-1:0] act,
    output logic signed [nn_pkg::DATA_W-1:0] weight
);
    import nn_pkg::*;

    logic signed [DATA_W-1:0] in_mem  [N_IN];   // Host-loaded input vector
    logic signed [DATA_W-1:0] w_mem   [N_W];    // Both layers, layer 1 first
    logic signed [DATA_W-1:0] hid_mem [N_HID];  // Layer-1 activations

    // Host loads only land while the engine is idle
    always_ff @(posedge clk) begin
        if (idle && in_we) begin
            in_mem[in_addr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (idle && w_we) begin
            w_mem[w_addr] <= w_data;
        end
    end

    always_ff @(posedge clk) begin
        if (hid_we) begin
            hid_mem[hid_addr] <= hid_data;  // Written back by the MAC
        end
    end

    // Registered reads, one cycle to the MAC
    always_ff @(posedge clk) begin
        if (rd_layer) begin
            act <= hid_mem[rd_act_addr[HID_AW-1:0]];
        end else begin
            act <= in_mem[rd_act_addr[IN_AW-1:0]];
        end
        weight <= w_mem[rd_w_addr];
    end

    // Host and writeback addresses stay inside the arrays
    assert property (@(posedge clk)
        (!(idle && in_we) || in_addr < N_IN) &&
        (!(idle && w_we) || w_addr < N_W) &&
        (!hid_we || hid_addr < N_HID));

endmodule

/* src/nn_sequencer.sv */
`timescale 1ns/1ps

module nn_sequencer #(
    parameter int  N_IN   = 16,
    parameter int  N_HID  = 8,
    parameter int  N_OUT  = 10,
    localparam int ACT_AW = $clog2(N_IN > N_HID ? N_IN : N_HID),
    localparam int IDX_W  = $clog2(N_HID > N_OUT ? N_HID : N_OUT),
    localparam int W_AW   = $clog2(N_IN * N_HID + N_HID * N_OUT)
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic              result_done,
    output nn_pkg::nn_state_t current_state,
    output logic              idle,
    output logic              rd_layer,
    output logic [ACT_AW-1:0] rd_act_addr,
    output logic [W_AW-1:0]   rd_w_addr,
    output logic              mac_clear,
    output logic              mac_en,
    output logic              mac_wb,
    output logic              wb_layer,
    output logic [IDX_W-1:0]  wb_idx,
    output logic              wb_last,
    output logic              run_start,
    output logic              done
);
    import nn_pkg::*;

    nn_state_t         state;
    logic [IDX_W-1:0]  neuron;       // Neuron within the layer
    logic [ACT_AW-1:0] op;           // Operand within the neuron
    logic              gap;          // Bubble so writeback gets its own slot
    logic              issue;        // Read issued this cycle
    logic              op_last;
    logic              neuron_last;
    logic              last_q;       // Last operand, at the MAC stage
    logic              layer_q;
    logic [IDX_W-1:0]  neuron_q;

    assign current_state = state;
    assign idle          = (state == ST_IDLE);
    assign done          = (state == ST_DONE);
    assign rd_layer      = (state == ST_LAYER2);  // Hidden memory in layer 2
    assign issue         = ((state == ST_LAYER1) || rd_layer) && !gap;

    assign op_last     = rd_layer ? (op == ACT_AW'(N_HID - 1)) : (op == ACT_AW'(N_IN - 1));
    assign neuron_last = rd_layer ? (neuron == IDX_W'(N_OUT - 1))
                                  : (neuron == IDX_W'(N_HID - 1));

    // Weight layout, layer 2 sits after all layer-1 words
    assign rd_act_addr = op;
    assign rd_w_addr   = rd_layer ? W_AW'(N_IN * N_HID + neuron * N_HID + op)
                                  : W_AW'(neuron * N_IN + op);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            neuron    <= '0;
            op        <= '0;
            gap       <= 1'b0;
            run_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_LAYER1;
                        run_start <= 1'b1;  // Clears the running max
                        neuron    <= '0;
                        op        <= '0;
                        gap       <= 1'b0;
                    end
                end
                ST_LAYER1, ST_LAYER2: begin
                    if (gap) begin
                        gap <= 1'b0;
                    end else if (op_last) begin
                        op  <= '0;
                        gap <= 1'b1;
                        if (neuron_last) begin
                            neuron <= '0;
                            state  <= (state == ST_LAYER1) ? ST_LAYER2 : ST_ARGMAX;
                        end else begin
                            neuron <= neuron + 1'b1;
                        end
                    end else begin
                        op <= op + 1'b1;
                    end
                end
                ST_ARGMAX: begin
                    if (result_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // MAC control, delayed to meet the read data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mac_en    <= 1'b0;
            mac_clear <= 1'b0;
            last_q    <= 1'b0;
            mac_wb    <= 1'b0;
        end else begin
            mac_en    <= issue;
            mac_clear <= issue && (op == '0);  // First product loads the acc
            last_q    <= issue && op_last;
            mac_wb    <= last_q;               // Cycle after the last mac_en
        end
    end

    always_ff @(posedge clk) begin
        layer_q  <= rd_layer;
        neuron_q <= neuron;
        wb_layer <= layer_q;
        wb_idx   <= neuron_q;
        wb_last  <= layer_q ? (neuron_q == IDX_W'(N_OUT - 1))
                            : (neuron_q == IDX_W'(N_HID - 1));
    end

    // Writeback slot never overlaps an accumulate
    assert property (@(posedge clk) disable iff (!resetn) !(mac_en && mac_wb));

    // A busy start neither reopens layer 1 nor flags a new run
    assert property (@(posedge clk) disable iff (!resetn)
        start && !idle |=> !run_start && (state != ST_LAYER1 || $past(state) == ST_LAYER1));

endmodule

/* src/nn_mac_unit.sv */
`timescale 1ns/1ps

module nn_mac_unit #(
    parameter int  N_HID  = 8,
    parameter int  N_OUT  = 10,
    parameter int  SHIFT  = 4,
    localparam int HID_AW = $clog2(N_HID),
    localparam int OUT_AW = $clog2(N_OUT),
    localparam int IDX_W  = $clog2(N_HID > N_OUT ? N_HID : N_OUT)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic signed [nn_pkg::DATA_W-1:0] act,
    input  logic signed [nn_pkg::DATA_W-1:0] weight,
    input  logic                             mac_clear,
    input  logic                             mac_en,
    input  logic                             mac_wb,
    input  logic                             wb_layer,
    input  logic [IDX_W-1:0]                 wb_idx,
    input  logic                             wb_last,
    output logic                             hid_we,
    output logic [HID_AW-1:0]                hid_addr,
    output logic signed [nn_pkg::DATA_W-1:0] hid_data,
    output logic                             score_valid,
    output logic signed [nn_pkg::ACC_W-1:0]  score,
    output logic [OUT_AW-1:0]                score_idx,
    output logic                             score_last
);
    import nn_pkg::*;

    localparam int SAT_MAX = 2 ** (DATA_W - 1) - 1;  // 127 for 8 bits

    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    shifted;
    logic signed [DATA_W-1:0]   act_fn;  // ReLU, shift, saturate

    assign prod    = act * weight;
    assign shifted = acc >>> SHIFT;

    always_comb begin
        if (acc < 0) begin
            act_fn = '0;                    // ReLU
        end else if (shifted > SAT_MAX) begin
            act_fn = DATA_W'(SAT_MAX);
        end else begin
            act_fn = shifted[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (mac_en) begin
            acc <= mac_clear ? ACC_W'(prod) : acc + ACC_W'(prod);
        end
    end

    // Layer picks the destination, hidden memory or result stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hid_we      <= 1'b0;
            score_valid <= 1'b0;
            score_last  <= 1'b0;
        end else begin
            hid_we      <= mac_wb && !wb_layer;
            score_valid <= mac_wb && wb_layer;
            score_last  <= mac_wb && wb_layer && wb_last;
        end
    end

    always_ff @(posedge clk) begin
        if (mac_wb) begin
            hid_addr  <= wb_idx[HID_AW-1:0];
            hid_data  <= act_fn;
            score     <= acc;                // Raw score, no activation
            score_idx <= wb_idx[OUT_AW-1:0];
        end
    end

endmodule

/* src/nn_result.sv */
`timescale 1ns/1ps

module nn_result #(
    parameter int  N_OUT  = 10,
    localparam int OUT_AW = $clog2(N_OUT)
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            run_start,
    input  logic                            score_valid,
    input  logic signed [nn_pkg::ACC_W-1:0] score,
    input  logic [OUT_AW-1:0]               score_idx,
    input  logic                            score_last,
    output logic [3:0]                      argmax_output,
    output logic [6:0]                      hex0,
    output logic                            result_done
);
    import nn_pkg::*;

    logic signed [ACC_W-1:0] best_score;
    logic [OUT_AW-1:0]       best_idx;
    logic                    better;
    logic                    armed;  // Between run_start and result_done

    // Strictly greater, so ties keep the lower index
    assign better = score > best_score;

    always_ff @(posedge clk) begin
        if (run_start) begin
            best_score <= {1'b1, {(ACC_W - 1){1'b0}}};  // Most negative
            best_idx   <= '0;
        end else if (score_valid && better) begin
            best_score <= score;
            best_idx   <= score_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed         <= 1'b0;
            result_done   <= 1'b0;
            argmax_output <= 4'd0;
        end else begin
            result_done <= score_valid && score_last;  // Best now includes last score
            if (run_start) begin
                armed <= 1'b1;
            end else if (result_done) begin
                armed <= 1'b0;
            end
            if (result_done) begin
                argmax_output <= 4'(best_idx);  // Same edge that raises done
            end
        end
    end

    // Active-low segments, blank in reset
    always_comb begin
        if (!resetn) begin
            hex0 = 7'b1111111;
        end else begin
            case (argmax_output)
                4'd0:    hex0 = 7'b1000000;
                4'd1:    hex0 = 7'b1111001;
                4'd2:    hex0 = 7'b0100100;
                4'd3:    hex0 = 7'b0110000;
                4'd4:    hex0 = 7'b0011001;
                4'd5:    hex0 = 7'b0010010;
                4'd6:    hex0 = 7'b0000010;
                4'd7:    hex0 = 7'b1111000;
                4'd8:    hex0 = 7'b0000000;
                4'd9:    hex0 = 7'b0010000;
                default: hex0 = 7'b1111111;  // Not a digit
            endcase
        end
    end

    // Scores only arrive inside a run the sequencer opened
    assert property (@(posedge clk) disable iff (!resetn) score_valid |-> armed);

endmodule

/* src/neural_network.sv */
`timescale 1ns/1ps

module neural_network #(
    parameter int  N_IN   = 16,
    parameter int  N_HID  = 8,
    parameter int  N_OUT  = 10,
    parameter int  SHIFT  = 4,
    localparam int IN_AW  = $clog2(N_IN),
    localparam int W_AW   = $clog2(N_IN * N_HID + N_HID * N_OUT)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             start,
    input  logic                             in_we,
    input  logic [IN_AW-1:0]                 in_addr,
    input  logic signed [nn_pkg::DATA_W-1:0] in_data,
    input  logic                             w_we,
    input  logic [W_AW-1:0]                  w_addr,
    input  logic signed [nn_pkg::DATA_W-1:0] w_data,
    output logic                             done,
    output nn_pkg::nn_state_t                current_state,
    output logic [3:0]                       argmax_output,
    output logic [6:0]                       hex0
);
    import nn_pkg::*;

    localparam int HID_AW = $clog2(N_HID);
    localparam int OUT_AW = $clog2(N_OUT);
    localparam int ACT_AW = $clog2(N_IN > N_HID ? N_IN : N_HID);
    localparam int IDX_W  = $clog2(N_HID > N_OUT ? N_HID : N_OUT);

    // Decode to buffers and MAC
    logic                     idle, rd_layer;
    logic [ACT_AW-1:0]        rd_act_addr;
    logic [W_AW-1:0]          rd_w_addr;
    logic                     mac_clear, mac_en, mac_wb;
    logic                     wb_layer, wb_last;
    logic [IDX_W-1:0]         wb_idx;
    logic signed [DATA_W-1:0] act, weight;
    // Writeback paths
    logic                     hid_we;
    logic [HID_AW-1:0]        hid_addr;
    logic signed [DATA_W-1:0] hid_data;
    logic                     score_valid, score_last;
    logic signed [ACC_W-1:0]  score;
    logic [OUT_AW-1:0]        score_idx;
    logic                     run_start, result_done;

    // Host strobes are gated by idle inside the buffers
    nn_buffers #(.N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT)) i_nn_buffers (
        .clk, .idle, .in_we, .in_addr, .in_data, .w_we, .w_addr, .w_data,
        .hid_we, .hid_addr, .hid_data, .rd_layer, .rd_act_addr, .rd_w_addr,
        .act, .weight
    );

    nn_sequencer #(.N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT)) i_nn_sequencer (
        .clk, .resetn, .start, .result_done, .current_state, .idle,
        .rd_layer, .rd_act_addr, .rd_w_addr, .mac_clear, .mac_en, .mac_wb,
        .wb_layer, .wb_idx, .wb_last, .run_start, .done
    );

    nn_mac_unit #(.N_HID(N_HID), .N_OUT(N_OUT), .SHIFT(SHIFT)) i_nn_mac_unit (
        .clk, .resetn, .act, .weight, .mac_clear, .mac_en, .mac_wb,
        .wb_layer, .wb_idx, .wb_last, .hid_we, .hid_addr, .hid_data,
        .score_valid, .score, .score_idx, .score_last
    );

    nn_result #(.N_OUT(N_OUT)) i_nn_result (
        .clk, .resetn, .run_start, .score_valid, .score, .score_idx,
        .score_last, .argmax_output, .hex0, .result_done
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2  // ns, so a 4 ns clock
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

/* tests/tb_neural_network.sv */
`timescale 1ns/1ps

module tb_neural_network;
    import nn_pkg::*;

    localparam int N_IN       = 16;
    localparam int N_HID      = 8;
    localparam int N_OUT      = 10;
    localparam int SHIFT      = 4;
    localparam int N_W        = N_IN * N_HID + N_HID * N_OUT;  // 208 weight words
    localparam int L2_BASE    = N_IN * N_HID;                  // First layer-2 weight
    localparam int MAX_RUNS   = 40;
    localparam int RUN_CYCLES = 400 + N_W;                     // Run plus a full load

    logic              clk;
    logic              resetn;
    logic              start;
    logic              in_we;
    logic [3:0]        in_addr;
    logic signed [7:0] in_data;
    logic              w_we;
    logic [7:0]        w_addr;
    logic signed [7:0] w_data;
    logic              done;
    nn_state_t         current_state;
    logic [3:0]        argmax_output;
    logic [6:0]        hex0;

    logic signed [7:0] in_vals [N_IN];  // Model copy of the input memory
    logic signed [7:0] w_vals  [N_W];   // Model copy of the weight memory
    integer            seed = 36;
    int                cycles;
    int                done_count;
    int                checks;
    int                errors;
    int                test_errors;

    tb_clock_gen i_clock_gen (.clk);

    neural_network #(
        .N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT), .SHIFT(SHIFT)
    ) i_neural_network (.*);

    // Cycle budget and done pulse count, sampled mid-cycle
    always @(negedge clk) begin
        cycles++;
        if (done) begin
            done_count++;
        end
        if (cycles >= MAX_RUNS * RUN_CYCLES) begin
            $display("Timeout: simulation still running after %0d clock cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_equal(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected) begin
            $display("FAIL at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "fail", test_errors);
        test_errors = 0;
    endtask

    // Active-low digit patterns of the board display
    function automatic logic [6:0] seg_pattern(input int digit);
        case (digit)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            9:       return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    // Expected class straight from the layer rules
    function automatic int model_class();
        int hid [N_HID];
        int sum;
        int best;
        int best_k;
        for (int j = 0; j < N_HID; j++) begin
            sum = 0;
            for (int i = 0; i < N_IN; i++)
                sum += in_vals[i] * w_vals[j * N_IN + i];
            if (sum < 0) begin
                hid[j] = 0;                          // ReLU
            end else if ((sum >>> SHIFT) > 127) begin
                hid[j] = 127;                        // Saturate to 8 bits
            end else begin
                hid[j] = sum >>> SHIFT;
            end
        end
        best   = 0;
        best_k = 0;
        for (int k = 0; k < N_OUT; k++) begin
            sum = 0;
            for (int j = 0; j < N_HID; j++)
                sum += hid[j] * w_vals[L2_BASE + k * N_HID + j];
            if (k == 0 || sum > best) begin      // Strictly greater, low index keeps a tie
                best   = sum;
                best_k = k;
            end
        end
        return best_k;
    endfunction

    task automatic randomize_network(input bit extreme);
        logic signed [7:0] v;
        for (int a = 0; a < N_IN + N_W; a++) begin
            v = 8'($random(seed));
            if (extreme) begin
                v = v[0] ? 8'sh7F : 8'sh80;  // Full scale either sign
            end
            if (a < N_IN) begin
                in_vals[a] = v;
            end else begin
                w_vals[a - N_IN] = v;
            end
        end
    endtask

    task automatic clear_network();
        foreach (in_vals[i])
            in_vals[i] = '0;
        foreach (w_vals[a])
            w_vals[a] = '0;
    endtask

    // One weight per cycle, inputs ride along on the first cycles
    task automatic load_network();
        for (int a = 0; a < N_W; a++) begin
            @(negedge clk);
            in_we   = (a < N_IN);
            in_addr = 4'(a);
            in_data = in_vals[a % N_IN];
            w_we    = 1'b1;
            w_addr  = 8'(a);
            w_data  = w_vals[a];
        end
        @(negedge clk);
        in_we = 1'b0;
        w_we  = 1'b0;
    endtask

    // Start pulse, wait for done, compare against the model
    task automatic run_network(input bit noisy, input string what);
        int expected;
        int pulses;
        expected = model_class();
        pulses   = done_count;
        @(negedge clk);
        check_equal(current_state, ST_IDLE, {what, ": idle before start"});
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_equal(current_state, ST_LAYER1, {what, ": state after start"});
        while (!done) begin
            @(negedge clk);
            if (noisy) begin
                start   = 1'($random(seed));  // All dropped while busy
                in_we   = 1'($random(seed));
                in_addr = 4'($random(seed));
                in_data = 8'($random(seed));
                w_we    = 1'($random(seed));
                w_addr  = 8'($unsigned($random(seed)) % N_W);
                w_data  = 8'($random(seed));
            end
        end
        start = 1'b0;  // Cleared before the edge back in idle
        in_we = 1'b0;
        w_we  = 1'b0;
        check_equal(argmax_output, expected, {what, ": class"});
        check_equal(hex0, seg_pattern(expected), {what, ": hex0"});
        repeat (3) @(negedge clk);
        check_equal(current_state, ST_IDLE, {what, ": back to idle"});
        check_equal(done_count - pulses, 1, {what, ": done pulses"});
    endtask

    initial begin
        resetn  = 1'b0;
        start   = 1'b0;
        in_we   = 1'b0;
        in_addr = '0;
        in_data = '0;
        w_we    = 1'b0;
        w_addr  = '0;
        w_data  = '0;
        repeat (10) @(negedge clk);
        check_equal(hex0, 7'h7F, "hex0 blank in reset");
        resetn = 1'b1;
        @(negedge clk);
        check_equal(current_state, ST_IDLE, "state after reset");
        check_equal(done, 0, "done after reset");
        check_equal(argmax_output, 0, "class after reset");
        report_test("reset");

        for (int n = 0; n < 30; n++) begin
            randomize_network(1'b0);
            load_network();
            run_network(1'b0, $sformatf("random %0d", n));
        end
        report_test("random networks");

        // Every hidden unit is 1, outputs 5 and 8 tie at 8
        clear_network();
        in_vals[0] = 8'sd16;
        for (int j = 0; j < N_HID; j++) begin
            w_vals[j * N_IN] = 8'sd1;
            w_vals[L2_BASE + 5 * N_HID + j] = 8'sd1;
            w_vals[L2_BASE + 8 * N_HID + j] = 8'sd1;
        end
        check_equal(model_class(), 5, "tie model");
        load_network();
        run_network(1'b0, "tie at top");
        for (int a = L2_BASE; a < N_W; a++)
            w_vals[a] = '0;                         // All scores zero
        check_equal(model_class(), 0, "zero tie model");
        load_network();
        run_network(1'b0, "all scores equal");
        report_test("argmax tie");

        // Hidden 0 saturates, hidden 1 cut by ReLU, hidden 2 stays at 63
        clear_network();
        for (int i = 0; i < N_IN; i++) begin
            in_vals[i]       = 8'sd127;
            w_vals[i]        = 8'sd127;
            w_vals[N_IN + i] = -8'sd127;
        end
        w_vals[2 * N_IN]            = 8'sd8;
        w_vals[L2_BASE + 2]         = 8'sd7;   // 441 from the unsaturated unit
        w_vals[L2_BASE + N_HID + 1] = 8'sh80;  // Would win without ReLU
        w_vals[L2_BASE + 2 * N_HID] = 8'sd4;   // 508 wins only if saturated
        check_equal(model_class(), 2, "saturation model");
        load_network();
        run_network(1'b0, "saturation crafted");
        for (int n = 0; n < 2; n++) begin
            randomize_network(1'b1);
            load_network();
            run_network(1'b0, $sformatf("full scale %0d", n));
        end
        report_test("saturation and relu");

        // Memories must survive the noise, so the repeat needs no reload
        randomize_network(1'b0);
        load_network();
        run_network(1'b1, "busy first run");
        run_network(1'b1, "busy repeat run");
        report_test("writes and start while busy");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
src/nn_pkg.sv
src/nn_buffers.sv
src/nn_sequencer.sv
src/nn_mac_unit.sv
src/nn_result.sv
src/neural_network.sv
tests/tb_clock_gen.sv
tests/tb_neural_network.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_neural_network -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished clean"
